// ==== common/dac_pkg.sv ====
package dac_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int DATA_WIDTH = 16;
	localparam int BATCH_SIZE = 4;
	localparam int BATCH_WIDTH = BATCH_SIZE * DATA_WIDTH;
	localparam int MEM_SIZE = 8;
	localparam int DMA_DATA_WIDTH = 48;
	localparam int SCALE_WIDTH = 4;
	localparam int PWL_DEPTH = 16;
	localparam int TRI_PEAK = 64;
	localparam logic [DATA_WIDTH-1:0] LFSR_TAPS = 16'hB400;

	localparam int ID_WIDTH = $clog2(MEM_SIZE);
	localparam int BATCH_SHIFT = $clog2(BATCH_SIZE); // segment lengths round down to this
	localparam int PWL_PTR_WIDTH = $clog2(PWL_DEPTH);
	localparam int TRI_PERIOD = 2 * TRI_PEAK;
	localparam int TRI_CNT_WIDTH = $clog2(TRI_PERIOD) + 1; // one spare bit for the wrap compare

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command ids and modes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [ID_WIDTH-1:0] {
		SEED_BASE_ID = 0,
		SEED_VALID_ID = 1,
		TRIG_WAVE_ID = 2,
		RUN_PWL_ID = 3,
		SCALE_ID = 4
	} reg_id_t;

	typedef enum logic [1:0] {
		MODE_IDLE,
		MODE_RAND,
		MODE_TRIG,
		MODE_PWL
	} dac_mode_t;

	// segment player states
	typedef enum logic [1:0] {
		PWL_IDLE,
		PWL_LOAD,
		PWL_PLAY
	} pwl_state_t;

endpackage

// ==== hw/dac_cmd_ctrl.sv ====
`timescale 1ns/10ps

module dac_cmd_ctrl import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  logic [MEM_SIZE-1:0] fresh_bits,
	input  logic [MEM_SIZE-1:0][DATA_WIDTH-1:0] read_resps,
	input  logic halt,
	output logic dac_intf_rdy,
	output dac_mode_t mode,
	output logic [DATA_WIDTH-1:0] seed,
	output logic seed_load,
	output logic pwl_load,
	output logic tri_restart,
	output logic [SCALE_WIDTH-1:0] scale
);

	reg_id_t pick_id;
	reg_id_t cmd_id;
	logic [DATA_WIDTH-1:0] cmd_word;
	logic serve;

	// lowest set fresh bit wins
	always_comb begin
		pick_id = SEED_BASE_ID;
		for (int i = MEM_SIZE - 1; i >= 0; i--) begin
			if (fresh_bits[i])
				pick_id = reg_id_t'(i);
		end
	end

	assign serve = |fresh_bits && !dac_intf_rdy; // the driver drops its bit after the ack

	always_ff @(posedge dac_clk) begin
		if (reset) begin
			dac_intf_rdy <= 1'b0;
		end else begin
			dac_intf_rdy <= serve;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (serve) begin
			cmd_id <= pick_id;
			cmd_word <= read_resps[pick_id];
		end
		if (dac_intf_rdy && cmd_id == SEED_BASE_ID)
			seed <= cmd_word;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command effects, one cycle after the ack
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge dac_clk) begin
		if (reset) begin
			mode <= MODE_IDLE;
			scale <= '0;
			seed_load <= 1'b0;
			pwl_load <= 1'b0;
			tri_restart <= 1'b0;
		end else begin
			seed_load <= 1'b0;
			pwl_load <= 1'b0;
			tri_restart <= 1'b0;
			if (halt) begin
				mode <= MODE_IDLE; // halt beats whatever command lands this cycle
			end else if (dac_intf_rdy) begin
				case (cmd_id)
					SEED_VALID_ID: begin
						if (cmd_word != '0) begin
							mode <= MODE_RAND;
							seed_load <= 1'b1;
						end
					end
					TRIG_WAVE_ID: begin
						mode <= MODE_TRIG;
						tri_restart <= 1'b1;
					end
					RUN_PWL_ID: begin
						mode <= MODE_PWL;
						pwl_load <= 1'b1;
					end
					default: ;
				endcase
			end
			if (dac_intf_rdy && cmd_id == SCALE_ID)
				scale <= cmd_word[SCALE_WIDTH-1:0];
		end
	end

	ack_one_cycle: assert property (@(posedge dac_clk) disable iff (reset)
		dac_intf_rdy |=> !dac_intf_rdy);

endmodule

// ==== sample_gen/lfsr_batch_gen.sv ====
`timescale 1ns/10ps

module lfsr_batch_gen import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  logic seed_load,
	input  logic [DATA_WIDTH-1:0] seed,
	input  logic advance,
	output logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] batch
);

	logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] state;
	logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] base;
	logic seeded;
	logic any_zero;

	function automatic logic [DATA_WIDTH-1:0] lfsr_step(input logic [DATA_WIDTH-1:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// a load shows through in the same cycle so the first batch is seed stepped once
	always_comb begin
		any_zero = 1'b0;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			base[i] = seed_load ? seed + DATA_WIDTH'(i) : state[i];
			if (base[i] == '0)
				base[i] = DATA_WIDTH'(1); // all-zero state would lock up
			batch[i] = lfsr_step(base[i]);
			if (state[i] == '0)
				any_zero = 1'b1;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (seed_load || advance) begin
			for (int i = 0; i < BATCH_SIZE; i++)
				state[i] <= advance ? batch[i] : base[i];
		end
	end

	always_ff @(posedge dac_clk) begin
		if (reset) begin
			seeded <= 1'b0;
		end else if (seed_load) begin
			seeded <= 1'b1;
		end
	end

	lanes_nonzero: assert property (@(posedge dac_clk) disable iff (reset)
		seeded |-> !any_zero);

endmodule

// ==== sample_gen/tri_batch_gen.sv ====
`timescale 1ns/10ps

module tri_batch_gen import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  logic tri_restart,
	input  logic advance,
	output logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] batch
);

	logic [TRI_CNT_WIDTH-1:0] count;
	logic [TRI_CNT_WIDTH-1:0] cur_count;
	logic [TRI_CNT_WIDTH-1:0] sum;
	logic [TRI_CNT_WIDTH-1:0] next_count;

	// reduce to one period, then fold the falling half about the peak
	function automatic logic [DATA_WIDTH-1:0] fold(input logic [TRI_CNT_WIDTH-1:0] k);
		logic [TRI_CNT_WIDTH-1:0] m;
		m = (k >= TRI_CNT_WIDTH'(TRI_PERIOD)) ? k - TRI_CNT_WIDTH'(TRI_PERIOD) : k;
		fold = (m > TRI_CNT_WIDTH'(TRI_PEAK)) ?
			DATA_WIDTH'(TRI_CNT_WIDTH'(TRI_PERIOD) - m) : DATA_WIDTH'(m);
	endfunction

	assign cur_count = tri_restart ? '0 : count;
	assign sum = cur_count + TRI_CNT_WIDTH'(BATCH_SIZE);
	assign next_count = (sum >= TRI_CNT_WIDTH'(TRI_PERIOD)) ? sum - TRI_CNT_WIDTH'(TRI_PERIOD) : sum;

	always_comb begin
		for (int i = 0; i < BATCH_SIZE; i++)
			batch[i] = fold(cur_count + TRI_CNT_WIDTH'(i));
	end

	always_ff @(posedge dac_clk) begin
		if (reset) begin
			count <= '0;
		end else if (tri_restart || advance) begin
			count <= advance ? next_count : cur_count;
		end
	end

endmodule

// ==== pwl/pwl_player.sv ====
`timescale 1ns/10ps

module pwl_player import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  logic pwl_load,
	input  logic [DMA_DATA_WIDTH-1:0] dma_data,
	input  logic dma_valid,
	input  logic dma_last,
	input  logic advance,
	output logic dma_ready,
	output logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] batch,
	output logic playing
);

	logic [DMA_DATA_WIDTH-1:0] seg_buf [PWL_DEPTH];
	pwl_state_t state;
	logic [PWL_PTR_WIDTH:0] seg_cnt;
	logic started; // low until the first advance of a play run

	// play position
	logic [PWL_PTR_WIDTH-1:0] seg_ptr;
	logic [DATA_WIDTH-1:0] acc;
	logic [DATA_WIDTH:0] offset;

	logic take;
	logic first_found, after_found;
	logic [PWL_PTR_WIDTH-1:0] first_idx, after_idx, cur_idx, next_idx;
	logic [DMA_DATA_WIDTH-1:0] cur_word, next_word;
	logic [DATA_WIDTH-1:0] cur_base, cur_slope;
	logic [DATA_WIDTH:0] cur_off, cur_len, step_off;

	// count rounded down to whole batches
	function automatic logic [DATA_WIDTH:0] seg_len(input logic [DMA_DATA_WIDTH-1:0] w);
		seg_len = {1'b0, w[DATA_WIDTH-1:BATCH_SHIFT], {BATCH_SHIFT{1'b0}}};
	endfunction

	assign dma_ready = state == PWL_LOAD && seg_cnt < (PWL_PTR_WIDTH+1)'(PWL_DEPTH);
	assign take = dma_valid && dma_ready;
	assign playing = state == PWL_PLAY && first_found; // nothing to play if every segment is empty

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// nonempty segment search
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		first_found = 1'b0;
		first_idx = '0;
		for (int i = PWL_DEPTH - 1; i >= 0; i--) begin
			if (i < seg_cnt && seg_len(seg_buf[i]) != '0) begin
				first_found = 1'b1;
				first_idx = PWL_PTR_WIDTH'(i);
			end
		end
	end

	always_comb begin
		after_found = 1'b0;
		after_idx = '0;
		for (int i = PWL_DEPTH - 1; i >= 0; i--) begin
			if (i < seg_cnt && i > cur_idx && seg_len(seg_buf[i]) != '0) begin
				after_found = 1'b1;
				after_idx = PWL_PTR_WIDTH'(i);
			end
		end
	end

	assign cur_idx = started ? seg_ptr : first_idx;
	assign cur_word = seg_buf[cur_idx];
	assign cur_base = started ? acc : cur_word[3*DATA_WIDTH-1 -: DATA_WIDTH];
	assign cur_slope = cur_word[2*DATA_WIDTH-1 -: DATA_WIDTH];
	assign cur_off = started ? offset : '0;
	assign cur_len = seg_len(cur_word);
	assign step_off = cur_off + (DATA_WIDTH+1)'(BATCH_SIZE);
	assign next_idx = after_found ? after_idx : first_idx; // wraps back to the first segment
	assign next_word = seg_buf[next_idx];

	always_comb begin
		for (int i = 0; i < BATCH_SIZE; i++)
			batch[i] = cur_base + DATA_WIDTH'(i) * cur_slope;
	end

	always_ff @(posedge dac_clk) begin
		if (reset) begin
			state <= PWL_IDLE;
			seg_cnt <= '0;
			started <= 1'b0;
		end else if (pwl_load) begin
			state <= PWL_LOAD;
			seg_cnt <= '0;
			started <= 1'b0;
		end else begin
			case (state)
				PWL_LOAD: begin
					if (take) begin
						seg_cnt <= seg_cnt + 1'b1;
						if (dma_last)
							state <= PWL_PLAY;
					end
				end
				PWL_PLAY: begin
					if (advance)
						started <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge dac_clk) begin
		if (take)
			seg_buf[seg_cnt[PWL_PTR_WIDTH-1:0]] <= dma_data;
		if (advance) begin
			if (step_off >= cur_len) begin
				seg_ptr <= next_idx;
				acc <= next_word[3*DATA_WIDTH-1 -: DATA_WIDTH];
				offset <= '0;
			end else begin
				seg_ptr <= cur_idx;
				acc <= cur_base + DATA_WIDTH'(BATCH_SIZE) * cur_slope;
				offset <= step_off;
			end
		end
	end

	no_ready_in_play: assert property (@(posedge dac_clk) disable iff (reset)
		!(dma_ready && playing));

endmodule

// ==== hw/batch_out.sv ====
`timescale 1ns/10ps

module batch_out import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  dac_mode_t mode,
	input  logic [SCALE_WIDTH-1:0] scale,
	input  logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] rand_batch,
	input  logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] tri_batch,
	input  logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] pwl_batch,
	input  logic pwl_playing,
	input  logic dac0_rdy,
	output logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] dac_batch,
	output logic valid_dac_batch,
	output logic rand_adv,
	output logic tri_adv,
	output logic pwl_adv
);

	logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] src_batch;
	logic src_ready;
	logic load;

	always_comb begin
		src_batch = '0;
		src_ready = 1'b0;
		case (mode)
			MODE_RAND: begin
				src_batch = rand_batch;
				src_ready = 1'b1;
			end
			MODE_TRIG: begin
				src_batch = tri_batch;
				src_ready = 1'b1;
			end
			MODE_PWL: begin
				src_batch = pwl_batch;
				src_ready = pwl_playing;
			end
			default: ;
		endcase
	end

	assign load = src_ready && (!valid_dac_batch || dac0_rdy); // register empty or being taken
	assign rand_adv = load && mode == MODE_RAND;
	assign tri_adv = load && mode == MODE_TRIG;
	assign pwl_adv = load && mode == MODE_PWL;

	always_ff @(posedge dac_clk) begin
		if (reset) begin
			valid_dac_batch <= 1'b0;
		end else if (load) begin
			valid_dac_batch <= 1'b1;
		end else if (dac0_rdy) begin
			valid_dac_batch <= 1'b0;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (load) begin
			for (int i = 0; i < BATCH_SIZE; i++)
				dac_batch[i] <= $signed(src_batch[i]) >>> scale;
		end
	end

	hold_on_stall: assert property (@(posedge dac_clk) disable iff (reset)
		valid_dac_batch && !dac0_rdy |=> valid_dac_batch && $stable(dac_batch));

endmodule

// ==== hw/dac_intf.sv ====
`timescale 1ns/10ps

module dac_intf import dac_pkg::*; (
	input  logic dac_clk,
	input  logic reset,
	input  logic [MEM_SIZE-1:0] fresh_bits,
	input  logic [MEM_SIZE-1:0][DATA_WIDTH-1:0] read_resps,
	input  logic halt,
	input  logic [DMA_DATA_WIDTH-1:0] dma_data,
	input  logic dma_valid,
	input  logic dma_last,
	input  logic dac0_rdy,
	output logic dac_intf_rdy,
	output logic dma_ready,
	output logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] dac_batch,
	output logic valid_dac_batch
);

	dac_mode_t mode;
	logic [DATA_WIDTH-1:0] seed;
	logic [SCALE_WIDTH-1:0] scale;
	logic seed_load, pwl_load, tri_restart;
	logic rand_adv, tri_adv, pwl_adv;
	logic pwl_playing;
	logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] rand_batch, tri_batch, pwl_batch;

	dac_cmd_ctrl cmd_ctrl (
		.dac_clk(dac_clk), .reset(reset),
		.fresh_bits(fresh_bits), .read_resps(read_resps), .halt(halt),
		.dac_intf_rdy(dac_intf_rdy), .mode(mode), .seed(seed),
		.seed_load(seed_load), .pwl_load(pwl_load), .tri_restart(tri_restart),
		.scale(scale)
	);

	lfsr_batch_gen rand_gen (
		.dac_clk(dac_clk), .reset(reset), .seed_load(seed_load), .seed(seed),
		.advance(rand_adv), .batch(rand_batch)
	);

	tri_batch_gen tri_gen (
		.dac_clk(dac_clk), .reset(reset), .tri_restart(tri_restart),
		.advance(tri_adv), .batch(tri_batch)
	);

	pwl_player pwl (
		.dac_clk(dac_clk), .reset(reset), .pwl_load(pwl_load),
		.dma_data(dma_data), .dma_valid(dma_valid), .dma_last(dma_last),
		.advance(pwl_adv), .dma_ready(dma_ready), .batch(pwl_batch),
		.playing(pwl_playing)
	);

	batch_out out (
		.dac_clk(dac_clk), .reset(reset), .mode(mode), .scale(scale),
		.rand_batch(rand_batch), .tri_batch(tri_batch), .pwl_batch(pwl_batch),
		.pwl_playing(pwl_playing), .dac0_rdy(dac0_rdy),
		.dac_batch(dac_batch), .valid_dac_batch(valid_dac_batch),
		.rand_adv(rand_adv), .tri_adv(tri_adv), .pwl_adv(pwl_adv)
	);

endmodule

// ==== tests/dac_intf_tb.sv ====
`timescale 1ns/10ps

module dac_intf_tb import dac_pkg::*; ();

	typedef logic [BATCH_SIZE-1:0][DATA_WIDTH-1:0] batch_t;
	localparam int WAIT_LIMIT = 2000;

	logic dac_clk = 1'b0;
	logic reset;
	logic [MEM_SIZE-1:0] fresh_bits;
	logic [MEM_SIZE-1:0][DATA_WIDTH-1:0] read_resps;
	logic halt;
	logic [DMA_DATA_WIDTH-1:0] dma_data;
	logic dma_valid;
	logic dma_last;
	logic dac0_rdy = 1'b1;
	logic dac_intf_rdy;
	logic dma_ready;
	logic valid_dac_batch;
	batch_t dac_batch;

	batch_t expected_q[$];
	int n_accepted = 0;
	logic [31:0] lcg_state = 32'd91056;
	logic rdy_random = 1'b0;
	int rdy_left = 0;
	logic held = 1'b0;
	batch_t held_batch;
	logic [DMA_DATA_WIDTH-1:0] segs [5];

	always #2 dac_clk = ~dac_clk;

	dac_intf uut (
		.dac_clk(dac_clk), .reset(reset), .fresh_bits(fresh_bits), .read_resps(read_resps),
		.halt(halt), .dma_data(dma_data), .dma_valid(dma_valid), .dma_last(dma_last),
		.dac0_rdy(dac0_rdy), .dac_intf_rdy(dac_intf_rdy), .dma_ready(dma_ready),
		.dac_batch(dac_batch), .valid_dac_batch(valid_dac_batch)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopped at the first failure");
	endtask

	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [DATA_WIDTH-1:0] lfsr_next(input logic [DATA_WIDTH-1:0] s);
		logic [DATA_WIDTH-1:0] r;
		r = s >> 1;
		if (s[0])
			r = r ^ LFSR_TAPS; // galois feedback on the bit shifted out
		return r;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] tri_sample(input int k);
		int m;
		m = k % (2 * TRI_PEAK);
		if (m > TRI_PEAK)
			m = 2 * TRI_PEAK - m;
		return DATA_WIDTH'(m);
	endfunction

	function automatic batch_t scaled(input batch_t b, input int sh);
		batch_t r;
		for (int i = 0; i < BATCH_SIZE; i++)
			r[i] = $signed(b[i]) >>> sh;
		return r;
	endfunction

	task automatic expect_random(input logic [DATA_WIDTH-1:0] seed, input int n);
		logic [DATA_WIDTH-1:0] lane [BATCH_SIZE];
		batch_t b;
		expected_q.delete();
		n_accepted = 0;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			lane[i] = seed + DATA_WIDTH'(i);
			if (lane[i] == '0)
				lane[i] = DATA_WIDTH'(1);
		end
		repeat (n) begin
			for (int i = 0; i < BATCH_SIZE; i++) begin
				lane[i] = lfsr_next(lane[i]);
				b[i] = lane[i];
			end
			expected_q.push_back(b);
		end
	endtask

	task automatic expect_tri(input int n, input int sh);
		batch_t b;
		expected_q.delete();
		n_accepted = 0;
		for (int k = 0; k < n; k++) begin
			for (int i = 0; i < BATCH_SIZE; i++)
				b[i] = tri_sample(k * BATCH_SIZE + i);
			expected_q.push_back(scaled(b, sh));
		end
	endtask

	// segments play in order, empty ones skipped, and the list repeats
	task automatic expect_pwl(input int n);
		batch_t b;
		int s;
		int j;
		int len;
		expected_q.delete();
		n_accepted = 0;
		s = 0;
		j = 0;
		while (n > 0) begin
			len = int'(segs[s][DATA_WIDTH-1:0]) / BATCH_SIZE * BATCH_SIZE;
			if (j >= len) begin
				s = (s + 1) % $size(segs);
				j = 0;
			end else begin
				for (int i = 0; i < BATCH_SIZE; i++)
					b[i] = segs[s][3*DATA_WIDTH-1 -: DATA_WIDTH]
						+ DATA_WIDTH'(j + i) * segs[s][2*DATA_WIDTH-1 -: DATA_WIDTH];
				expected_q.push_back(b);
				j += BATCH_SIZE;
				n--;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// DAC side: back-pressure and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge dac_clk) begin
		#1;
		if (!rdy_random) begin
			dac0_rdy = 1'b1;
		end else begin
			if (rdy_left == 0) begin
				dac0_rdy = !dac0_rdy;
				rdy_left = 1 + next_rand() % 3; // each level lasts 1 to 3 cycles
			end
			rdy_left--;
		end
	end

	always @(negedge dac_clk) begin
		if (held) begin
			assert (valid_dac_batch && dac_batch == held_batch) else
				report_failure($sformatf("Error at %0t: held batch changed from %h to %h",
					$time, held_batch, dac_batch));
		end
		held = valid_dac_batch && !dac0_rdy && !reset;
		held_batch = dac_batch;
		if (valid_dac_batch && dac0_rdy && !reset) begin
			assert (expected_q.size() > 0) else
				report_failure("A batch was accepted when no batch was expected");
			assert (dac_batch == expected_q[0]) else
				report_failure($sformatf("Error at %0t: batch %0d is %h, expected %h",
					$time, n_accepted, dac_batch, expected_q[0]));
			void'(expected_q.pop_front());
			n_accepted++;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic notify(input reg_id_t id, input logic [DATA_WIDTH-1:0] word);
		int cycles;
		@(posedge dac_clk);
		#1;
		read_resps[id] = word;
		fresh_bits[id] = 1'b1;
		cycles = 0;
		while (!dac_intf_rdy) begin
			@(posedge dac_clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_failure($sformatf("Timed out waiting for dac_intf_rdy after command %0d", id));
		end
		fresh_bits[id] = 1'b0;
	endtask

	task automatic send_dma(input logic [DMA_DATA_WIDTH-1:0] word, input logic last);
		int cycles;
		repeat (next_rand() % 4) begin
			@(posedge dac_clk);
			#1;
		end
		dma_data = word;
		dma_valid = 1'b1;
		dma_last = last;
		cycles = 0;
		@(negedge dac_clk);
		while (!dma_ready) begin
			@(negedge dac_clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_failure("Timed out waiting for dma_ready");
		end
		@(posedge dac_clk); // the word transfers on this edge
		#1;
		dma_valid = 1'b0;
		dma_last = 1'b0;
	endtask

	task automatic wait_accepted(input int n);
		int cycles;
		cycles = 0;
		while (n_accepted < n) begin
			@(posedge dac_clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_failure($sformatf("Timed out with %0d of %0d batches accepted", n_accepted, n));
		end
	endtask

	task automatic halt_output();
		int cycles;
		@(posedge dac_clk);
		#1;
		halt = 1'b1;
		@(posedge dac_clk);
		#1;
		halt = 1'b0;
		cycles = 0;
		while (valid_dac_batch) begin
			@(posedge dac_clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_failure("Timed out waiting for valid_dac_batch to fall after halt");
		end
	endtask

	task automatic check_quiet_outputs();
		assert (!valid_dac_batch && !dac_intf_rdy && !dma_ready) else
			report_failure($sformatf("Error at %0t: valid %b rdy %b dma_ready %b around reset",
				$time, valid_dac_batch, dac_intf_rdy, dma_ready));
	endtask

	initial begin
		reset = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		halt = 1'b0;
		dma_data = '0;
		dma_valid = 1'b0;
		dma_last = 1'b0;
		segs[0] = {16'd100, 16'd5, 16'd12};
		segs[1] = {16'd1000, 16'hFFEC, 16'd10}; // falling, count rounds down to 8
		segs[2] = {16'd7, 16'd3, 16'd0}; // empty, skipped
		segs[3] = {16'hFFF0, 16'd7, 16'd8};
		segs[4] = {16'h8000, 16'h0100, 16'd4};
		repeat (3) begin
			@(posedge dac_clk);
			#1;
			check_quiet_outputs();
		end
		reset = 1'b0;
		repeat (2) begin
			@(posedge dac_clk);
			#1;
			check_quiet_outputs();
		end

		rdy_random = 1'b1;
		expect_random(16'hBEEF, 24);
		notify(SEED_BASE_ID, 16'hBEEF);
		notify(SEED_VALID_ID, 16'h0001);
		wait_accepted(16);
		halt_output();

		expect_tri(48, 0);
		notify(TRIG_WAVE_ID, 16'h0000);
		wait_accepted(40);
		halt_output();

		notify(SCALE_ID, 16'd3);
		expect_tri(48, 3);
		notify(TRIG_WAVE_ID, 16'h0000);
		wait_accepted(40);
		halt_output();

		notify(SCALE_ID, 16'd0);
		expect_pwl(32);
		notify(RUN_PWL_ID, 16'h0000);
		for (int s = 0; s < $size(segs); s++)
			send_dma(segs[s], s == $size(segs) - 1);
		wait_accepted(16); // two loops of eight batches

		halt_output();
		repeat (50) begin
			@(posedge dac_clk);
			#1;
			assert (!valid_dac_batch && !dac_intf_rdy) else
				report_failure($sformatf("Error at %0t: output active after halt", $time));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== flist.f ====
common/dac_pkg.sv
hw/dac_cmd_ctrl.sv
sample_gen/lfsr_batch_gen.sv
sample_gen/tri_batch_gen.sv
pwl/pwl_player.sv
hw/batch_out.sv
hw/dac_intf.sv
tests/dac_intf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dac_intf_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
EXTRA_FLAGS ?= -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert $(EXTRA_FLAGS) --top-module $(TOP) \
		-f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
